// ==== compile.f ====
src/id_pkg.sv
src/reg_file.sv
src/ctrl_decode.sv
src/hazard_fsm.sv
src/redirect_timer.sv
src/pipe_reg.sv
src/id_stage.sv
verif/clk_gen.sv
verif/id_stage_tb.sv

// ==== verif/id_stage_tb.sv ====
// Hazard flags per row are hand-derived; ID/EX values come from a register-mirroring model
`default_nettype none
`timescale 1ns/1ps

module id_stage_tb;

    import id_pkg::*;

    typedef struct packed {
        logic [15:0] inst;
        logic        wb_en;
        logic [3:0]  wb_rd;
        logic        ie_wr;
        logic [3:0]  ie_rd;
        logic        em_wr;
        logic [3:0]  em_rd;
        logic        mw_wr;
        logic [3:0]  mw_rd;
        logic        ex_stall;
        logic        pc_update;
        logic        pc_hz;         // pc_hazard_in from IF
        logic        exp_dh;
        logic        exp_ch;
        logic        exp_halt;
    } step_t;

    logic        clk;
    logic        rst;
    logic [15:0] inst;
    logic [15:0] pc_in;
    logic [15:0] wb_data;
    logic        wb_en;
    logic [3:0]  wb_rd;
    logic [3:0]  id_ex_rd;
    logic [3:0]  ex_mem_rd;
    logic [3:0]  mem_wb_rd;
    logic        id_ex_wr;
    logic        ex_mem_wr;
    logic        mem_wb_wr;
    logic        pc_hazard_in;
    logic        pc_update;
    logic        ex_stall;
    ctrl_word_t  ex_ctrl;
    data_word_t  ex_data;
    logic        data_hazard;
    logic        ctrl_hazard;
    logic        halted;
    logic        stall_fetch;

    step_t       steps[$];
    step_t       idle_step;
    logic        table_ready = 1'b0;
    logic [31:0] seed = 32'heff9927a;
    logic [15:0] cur_wb_data;
    logic [15:0] cur_pc;
    logic [15:0] model_regs [16];   // Mirror of the register file
    ctrl_word_t  exp_ctrl;
    data_word_t  exp_data;
    int          n_errors = 0;

    clk_gen #(.period_ns(100.0)) u_clk_gen (.clk(clk));

    id_stage i_id_stage (.*);

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    // Control word straight from the opcode table
    function automatic ctrl_word_t ref_ctrl(input logic [3:0] op);
        ctrl_word_t c;
        case (op)
            op_add, op_sub, op_nand, op_xor, op_inc:
                c = '{reg_write: 1, alu_op: op[2:0], default: 0};
            op_sra, op_srl, op_sll:
                c = '{reg_write: 1, alu_src: 1, alu_op: op[2:0], default: 0};
            op_lw:   c = '{reg_write: 1, mem_read: 1, mem_to_reg: 1, alu_src: 1, default: 0};
            op_sw:   c = '{mem_write: 1, alu_src: 1, default: 0};
            op_lhb:  c = '{reg_write: 1, alu_src: 1, load_half: 1, default: 0};
            op_llb:  c = '{reg_write: 1, alu_src: 1, load_half: 1, half_spec: 1, default: 0};
            op_b:    c = '{branch: 1, alu_op: alu_nop, default: 0};
            op_call: c = '{call: 1, alu_op: alu_nop, default: 0};
            op_ret:  c = '{ret: 1, alu_op: alu_nop, default: 0};
            default: c = '{alu_op: alu_nop, default: 0};    // hlt
        endcase
        return c;
    endfunction

    task automatic check_val(input string name, input logic [95:0] got, input logic [95:0] want);
        if (got !== want) begin
            n_errors++;
            $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, want);
            $display("SIMULATION FAILED");
            $fatal(1);
        end
    endtask

    // Row fields are inst, {wb_en,wb_rd}, {wr,rd} for ID/EX, EX/MEM, MEM/WB,
    // {ex_stall,pc_update,pc_hazard_in} and expected {data_hazard,ctrl_hazard,halted}
    task automatic add_step(input logic [15:0] i, input logic [4:0] wb, input logic [4:0] ie,
                            input logic [4:0] em, input logic [4:0] mw,
                            input logic [2:0] ctl, input logic [2:0] expv);
        step_t s;
        s.inst = i;
        {s.wb_en, s.wb_rd} = wb;
        {s.ie_wr, s.ie_rd} = ie;
        {s.em_wr, s.em_rd} = em;
        {s.mw_wr, s.mw_rd} = mw;
        {s.ex_stall, s.pc_update, s.pc_hz} = ctl;
        {s.exp_dh, s.exp_ch, s.exp_halt} = expv;
        steps.push_back(s);
    endtask

    task automatic build_table;
        add_step(16'h0100, 5'h11, 5'h00, 5'h00, 5'h00, 3'b000, 3'b000);  // r0 reads zero
        add_step(16'h0210, 5'h12, 5'h00, 5'h00, 5'h00, 3'b000, 3'b000);  // r1 from last write
        add_step(16'h1312, 5'h13, 5'h00, 5'h00, 5'h00, 3'b000, 3'b000);  // sub r3,r1,r2
        add_step(16'hD123, 5'h14, 5'h00, 5'h00, 5'h00, 3'b000, 3'b000);  // call reads r15 as FFFF
        add_step(16'h0433, 5'h00, 5'h00, 5'h00, 5'h00, 3'b000, 3'b010);  // Drain 1
        add_step(16'h0433, 5'h00, 5'h00, 5'h00, 5'h00, 3'b010, 3'b010);  // pc_update ignored
        add_step(16'h0433, 5'h00, 5'h00, 5'h00, 5'h00, 3'b000, 3'b010);  // Drain 3
        add_step(16'h0433, 5'h00, 5'h00, 5'h00, 5'h00, 3'b000, 3'b010);  // Waiting for PC
        add_step(16'h0433, 5'h00, 5'h00, 5'h00, 5'h00, 3'b010, 3'b010);
        add_step(16'h0543, 5'h15, 5'h00, 5'h00, 5'h00, 3'b000, 3'b000);  // Back to idle
        add_step(16'h2612, 5'h1E, 5'h00, 5'h00, 5'h00, 3'b000, 3'b000);  // nand
        add_step(16'h3734, 5'h1D, 5'h00, 5'h00, 5'h00, 3'b000, 3'b000);  // xor
        add_step(16'h4850, 5'h15, 5'h00, 5'h00, 5'h00, 3'b000, 3'b000);  // inc reads r5 as rewritten
        add_step(16'h591D, 5'h16, 5'h00, 5'h00, 5'h00, 3'b000, 3'b000);  // sra with negative imm4
        add_step(16'h6A25, 5'h17, 5'h00, 5'h00, 5'h00, 3'b000, 3'b000);  // srl
        add_step(16'h7B3F, 5'h18, 5'h00, 5'h00, 5'h00, 3'b000, 3'b000);  // sll
        add_step(16'h8C80, 5'h00, 5'h00, 5'h00, 5'h00, 3'b000, 3'b000);  // lw with base r14
        add_step(16'h9D7F, 5'h1A, 5'h00, 5'h00, 5'h00, 3'b000, 3'b000);  // sw storing r13
        add_step(16'hAE5A, 5'h1B, 5'h00, 5'h00, 5'h00, 3'b000, 3'b000);  // lhb
        add_step(16'hB2C3, 5'h1C, 5'h00, 5'h00, 5'h00, 3'b000, 3'b000);  // llb
        add_step(16'h0123, 5'h00, 5'h12, 5'h00, 5'h00, 3'b000, 3'b100);  // rs in ID/EX
        add_step(16'h0123, 5'h00, 5'h00, 5'h13, 5'h00, 3'b000, 3'b100);  // rt in EX/MEM
        add_step(16'h0123, 5'h00, 5'h00, 5'h00, 5'h12, 3'b000, 3'b100);  // rs in MEM/WB
        add_step(16'h0123, 5'h00, 5'h02, 5'h11, 5'h00, 3'b000, 3'b000);  // No write flag or dest
        add_step(16'h5123, 5'h00, 5'h13, 5'h00, 5'h00, 3'b000, 3'b000);  // Unused rt
        add_step(16'h5123, 5'h00, 5'h00, 5'h00, 5'h12, 3'b000, 3'b100);
        add_step(16'h9340, 5'h00, 5'h00, 5'h13, 5'h00, 3'b000, 3'b100);  // sw store reg
        add_step(16'h8340, 5'h00, 5'h00, 5'h13, 5'h00, 3'b000, 3'b000);  // lw dest is no source
        add_step(16'hD000, 5'h00, 5'h00, 5'h00, 5'h1F, 3'b000, 3'b100);  // call blocked on SP
        add_step(16'hA500, 5'h00, 5'h15, 5'h00, 5'h00, 3'b000, 3'b100);  // lhb reads its dest
        add_step(16'h0123, 5'h11, 5'h00, 5'h00, 5'h00, 3'b000, 3'b000);
        add_step(16'h3456, 5'h00, 5'h00, 5'h00, 5'h00, 3'b100, 3'b000);  // Hold starts
        add_step(16'h0123, 5'h00, 5'h12, 5'h00, 5'h00, 3'b100, 3'b100);  // Hold over hazard
        add_step(16'hD000, 5'h00, 5'h00, 5'h00, 5'h00, 3'b100, 3'b000);  // call not taken
        add_step(16'h2156, 5'h00, 5'h00, 5'h00, 5'h00, 3'b001, 3'b000);  // IF bubble only
        add_step(16'h4123, 5'h00, 5'h00, 5'h00, 5'h00, 3'b000, 3'b000);
        add_step(16'hC5AB, 5'h00, 5'h00, 5'h00, 5'h00, 3'b000, 3'b000);  // b passes to EX
        add_step(16'h0123, 5'h00, 5'h00, 5'h00, 5'h00, 3'b000, 3'b010);
        add_step(16'h0123, 5'h00, 5'h00, 5'h00, 5'h00, 3'b100, 3'b010);  // Timer runs on
        add_step(16'h0123, 5'h00, 5'h00, 5'h00, 5'h00, 3'b010, 3'b010);  // Still draining
        add_step(16'h0123, 5'h00, 5'h00, 5'h00, 5'h00, 3'b010, 3'b010);
        add_step(16'hE000, 5'h00, 5'h00, 5'h00, 5'h00, 3'b000, 3'b000);  // ret
        add_step(16'h0123, 5'h00, 5'h00, 5'h00, 5'h00, 3'b000, 3'b010);
        add_step(16'h0123, 5'h00, 5'h00, 5'h00, 5'h00, 3'b000, 3'b010);
        add_step(16'h0123, 5'h00, 5'h00, 5'h00, 5'h00, 3'b000, 3'b010);
        add_step(16'h0123, 5'h00, 5'h00, 5'h00, 5'h00, 3'b000, 3'b010);
        add_step(16'h0123, 5'h00, 5'h00, 5'h00, 5'h00, 3'b010, 3'b010);
        add_step(16'h0213, 5'h12, 5'h00, 5'h00, 5'h00, 3'b000, 3'b000);
        add_step(16'hF000, 5'h00, 5'h00, 5'h00, 5'h00, 3'b000, 3'b000);  // hlt
        add_step(16'h0123, 5'h00, 5'h00, 5'h00, 5'h00, 3'b000, 3'b001);
        add_step(16'hD000, 5'h00, 5'h00, 5'h00, 5'h00, 3'b010, 3'b001);
        add_step(16'h8340, 5'h00, 5'h00, 5'h00, 5'h00, 3'b000, 3'b001);
    endtask

    task automatic apply_step(input step_t s);
        seed = xorshift(seed);
        cur_wb_data = seed[15:0];
        seed = xorshift(seed);
        cur_pc = seed[31:16];
        inst         <= s.inst;
        pc_in        <= cur_pc;
        wb_data      <= cur_wb_data;
        wb_en        <= s.wb_en;
        wb_rd        <= s.wb_rd;
        id_ex_wr     <= s.ie_wr;
        id_ex_rd     <= s.ie_rd;
        ex_mem_wr    <= s.em_wr;
        ex_mem_rd    <= s.em_rd;
        mem_wb_wr    <= s.mw_wr;
        mem_wb_rd    <= s.mw_rd;
        ex_stall     <= s.ex_stall;
        pc_update    <= s.pc_update;
        pc_hazard_in <= s.pc_hz;
    endtask

    // Next ID/EX contents and then the write-back into the mirror
    task automatic predict(input step_t s);
        logic [3:0] op;
        logic [3:0] a1;
        logic [3:0] a2;
        data_word_t d;
        op = s.inst[15:12];
        a1 = s.inst[7:4];                           // Unused ports still read rs/rt
        a2 = s.inst[3:0];
        if (op == op_lw || op == op_sw) a1 = reg_ds;
        if (op == op_lhb || op == op_llb) a1 = s.inst[11:8];
        if (op == op_call || op == op_ret) a1 = reg_sp;
        if (op == op_sw) a2 = s.inst[11:8];
        d.read_data_1 = model_regs[a1];
        d.read_data_2 = model_regs[a2];
        if (op >= op_lw && op <= op_llb) d.sign_ext = 16'($signed(s.inst[7:0]));
        else d.sign_ext = 16'($signed(s.inst[3:0]));
        d.dest_reg    = s.inst[11:8];
        d.branch_cond = s.inst[10:8];
        d.call_target = s.inst[11:0];
        d.pc          = cur_pc;
        if (!s.ex_stall) begin
            if (s.exp_dh || s.exp_ch || s.exp_halt || s.pc_hz) begin
                exp_ctrl = ctrl_bubble;
                exp_data = '0;
            end else begin
                exp_ctrl = ref_ctrl(op);
                exp_data = d;
            end
        end
        if (s.wb_en) model_regs[s.wb_rd] = cur_wb_data;
    endtask

    task automatic check_regs;
        check_val("ex_ctrl", ex_ctrl, exp_ctrl);
        check_val("ex_data", ex_data, exp_data);
    endtask

    task automatic check_comb(input step_t s);
        check_val("data_hazard", data_hazard, s.exp_dh);
        check_val("ctrl_hazard", ctrl_hazard, s.exp_ch);
        check_val("halted", halted, s.exp_halt);
        check_val("stall_fetch", stall_fetch, s.exp_dh | s.ex_stall | s.exp_ch | s.exp_halt);
    endtask

    // Ten cycles of rst with idle inputs and a check of the reset state
    task automatic do_reset;
        @(posedge clk);
        rst <= 1'b1;
        apply_step(idle_step);
        @(negedge clk);
        check_regs();                               // Result of the last row
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        for (int r = 0; r < 16; r++) model_regs[r] = (r == 15) ? sp_reset : 16'h0000;
        exp_ctrl = ctrl_bubble;
        exp_data = '0;
        check_regs();
        check_comb(idle_step);                      // All hazard flags low
    endtask

    initial begin
        wait (table_ready);
        #((steps.size() + 40) * 100);               // Rows plus reset margin at 100 ns each
        $display("ERROR: watchdog timeout, the test sequence did not finish in time");
        $display("SIMULATION FAILED");
        $fatal(1);
    end

    initial begin
        exp_ctrl = ctrl_bubble;
        exp_data = '0;
        idle_step = '0;
        idle_step.pc_hz = 1'b1;                     // Keeps ID/EX a bubble between phases
        rst <= 1'b1;
        apply_step(idle_step);
        build_table();
        table_ready = 1'b1;
        do_reset();
        foreach (steps[i]) begin
            @(posedge clk);
            apply_step(steps[i]);
            @(negedge clk);
            check_regs();                           // Latched from the previous row
            check_comb(steps[i]);
            predict(steps[i]);
        end
        do_reset();                                 // Also clears halted
        if (n_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/clk_gen.sv ====
// Free-running testbench clock; starts low, so the first rising edge comes after half a period
`default_nettype none
`timescale 1ns/1ps

module clk_gen #(
    parameter real period_ns = 100.0
) (
    output logic clk
);

    initial clk = 1'b0;

    always #(period_ns / 2.0) clk = ~clk;   // 50/50 duty

endmodule

`default_nettype wire

// ==== src/id_stage.sv ====
// ID stage of the 16-bit pipe; no forwarding, hazards stall, branch conditions are resolved in EX
`default_nettype none
`timescale 1ns/1ps

module id_stage (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [id_pkg::data_w-1:0] inst,          // From IF/ID
    input  logic [id_pkg::data_w-1:0] pc_in,
    input  logic [id_pkg::data_w-1:0] wb_data,
    input  logic                      wb_en,
    input  logic [id_pkg::reg_w-1:0]  wb_rd,
    input  logic [id_pkg::reg_w-1:0]  id_ex_rd,      // In-flight destinations
    input  logic [id_pkg::reg_w-1:0]  ex_mem_rd,
    input  logic [id_pkg::reg_w-1:0]  mem_wb_rd,
    input  logic                      id_ex_wr,
    input  logic                      ex_mem_wr,
    input  logic                      mem_wb_wr,
    input  logic                      pc_hazard_in,  // IF asks for a bubble
    input  logic                      pc_update,     // New PC taken, one pulse
    input  logic                      ex_stall,
    output id_pkg::ctrl_word_t        ex_ctrl,
    output id_pkg::data_word_t        ex_data,
    output logic                      data_hazard,
    output logic                      ctrl_hazard,
    output logic                      halted,
    output logic                      stall_fetch
);

    import id_pkg::*;

    logic [3:0]        opcode;
    logic [reg_w-1:0]  dest;
    logic [reg_w-1:0]  rs;
    logic [reg_w-1:0]  rt;
    logic [reg_w-1:0]  rd_addr_1;
    logic [reg_w-1:0]  rd_addr_2;
    logic [data_w-1:0] rd_data_1;
    logic [data_w-1:0] rd_data_2;
    logic [data_w-1:0] sign_ext;
    ctrl_word_t        dec_ctrl;
    data_word_t        dec_data;
    logic [1:0]        sel_1;
    logic              sel_2;
    logic              use_1;
    logic              use_2;
    logic              imm8_sel;
    logic              xfer;
    logic              hlt;
    logic              hit_1;
    logic              hit_2;
    logic              timer_start;
    logic              timer_done;
    logic              flush;

    // Instruction fields
    assign opcode = inst[15:12];
    assign dest   = inst[11:8];     // Also the sw data register
    assign rs     = inst[7:4];
    assign rt     = inst[3:0];

    ctrl_decode u_ctrl_decode (
        .opcode   (opcode),
        .ctrl     (dec_ctrl),
        .sel_1    (sel_1),
        .sel_2    (sel_2),
        .use_1    (use_1),
        .use_2    (use_2),
        .imm8_sel (imm8_sel),
        .xfer     (xfer),
        .hlt      (hlt)
    );

    // Read port address selects
    always_comb begin
        case (sel_1)
            2'd0:    rd_addr_1 = rs;
            2'd1:    rd_addr_1 = dest;      // lhb/llb
            2'd2:    rd_addr_1 = reg_ds;    // lw/sw base
            default: rd_addr_1 = reg_sp;    // call/ret
        endcase
    end

    assign rd_addr_2 = sel_2 ? dest : rt;

    reg_file u_reg_file (
        .clk       (clk),
        .rst       (rst),
        .wr_en     (wb_en),
        .rd_addr_1 (rd_addr_1),
        .rd_addr_2 (rd_addr_2),
        .wr_addr   (wb_rd),
        .wr_data   (wb_data),
        .rd_data_1 (rd_data_1),
        .rd_data_2 (rd_data_2)
    );

    // imm8 for memory and half loads, imm4 for shifts
    assign sign_ext = imm8_sel ? {{8{inst[7]}}, inst[7:0]} : {{12{inst[3]}}, inst[3:0]};

    // RAW check against every later stage that will write
    assign hit_1 = (id_ex_wr  && rd_addr_1 == id_ex_rd)
                || (ex_mem_wr && rd_addr_1 == ex_mem_rd)
                || (mem_wb_wr && rd_addr_1 == mem_wb_rd);
    assign hit_2 = (id_ex_wr  && rd_addr_2 == id_ex_rd)
                || (ex_mem_wr && rd_addr_2 == ex_mem_rd)
                || (mem_wb_wr && rd_addr_2 == mem_wb_rd);
    assign data_hazard = (use_1 && hit_1) || (use_2 && hit_2);

    hazard_fsm u_hazard_fsm (
        .clk         (clk),
        .rst         (rst),
        .xfer        (xfer),
        .hlt         (hlt),
        .data_hazard (data_hazard),
        .ex_stall    (ex_stall),
        .timer_done  (timer_done),
        .pc_update   (pc_update),
        .timer_start (timer_start),
        .ctrl_hazard (ctrl_hazard),
        .halted      (halted)
    );

    redirect_timer u_redirect_timer (
        .clk   (clk),
        .rst   (rst),
        .start (timer_start),
        .done  (timer_done)
    );

    // Operand payload
    assign dec_data.read_data_1 = rd_data_1;
    assign dec_data.read_data_2 = rd_data_2;
    assign dec_data.sign_ext    = sign_ext;
    assign dec_data.dest_reg    = dest;
    assign dec_data.branch_cond = inst[10:8];
    assign dec_data.call_target = inst[11:0];
    assign dec_data.pc          = pc_in;

    assign flush       = data_hazard || ctrl_hazard || halted || pc_hazard_in;
    assign stall_fetch = data_hazard || ex_stall || ctrl_hazard || halted;  // IF keeps inst

    pipe_reg #(
        .payload_t (ctrl_word_t),
        .flush_val (ctrl_bubble)
    ) u_ctrl_reg (
        .clk   (clk),
        .rst   (rst),
        .hold  (ex_stall),
        .flush (flush),
        .d     (dec_ctrl),
        .q     (ex_ctrl)
    );

    pipe_reg #(
        .payload_t (data_word_t),
        .flush_val (data_bubble)
    ) u_data_reg (
        .clk   (clk),
        .rst   (rst),
        .hold  (ex_stall),
        .flush (flush),
        .d     (dec_data),
        .q     (ex_data)
    );

endmodule

`default_nettype wire

// ==== src/pipe_reg.sv ====
// Generic pipeline register; hold beats flush, reset and flush both load flush_val
`default_nettype none
`timescale 1ns/1ps

module pipe_reg #(
    parameter type      payload_t = logic,
    parameter payload_t flush_val = '0
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     hold,      // Back-pressure from EX
    input  logic     flush,     // Insert a bubble
    input  payload_t d,
    output payload_t q
);

    always_ff @(posedge clk) begin
        if (rst) begin
            q <= flush_val;
        end else if (!hold) begin
            if (flush) begin
                q <= flush_val;
            end else begin
                q <= d;
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/redirect_timer.sv ====
// Bubble timer; runs freely under ex_stall so the redirect bubble count is fixed in cycles
`default_nettype none
`timescale 1ns/1ps

module redirect_timer (
    input  logic clk,
    input  logic rst,
    input  logic start,
    output logic done
);

    import id_pkg::*;

    localparam int cnt_w = $clog2(redirect_cycles + 1);

    logic [cnt_w-1:0] count;

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else if (start) begin
            count <= cnt_w'(redirect_cycles);   // Reload
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    // Last bubble cycle, one pulse per start
    assign done = (count == cnt_w'(1));

endmodule

`default_nettype wire

// ==== src/hazard_fsm.sv ====
// Stall/redirect sequencer; takes a transfer or hlt only when idle and unstalled, HALTED needs rst
`default_nettype none
`timescale 1ns/1ps

module hazard_fsm (
    input  logic clk,
    input  logic rst,
    input  logic xfer,
    input  logic hlt,
    input  logic data_hazard,
    input  logic ex_stall,
    input  logic timer_done,
    input  logic pc_update,
    output logic timer_start,
    output logic ctrl_hazard,
    output logic halted
);

    typedef enum logic [1:0] {
        s_idle,
        s_drain,        // Counting bubbles after a transfer
        s_wait_pc,      // Bubbles until IF has the new PC
        s_halted
    } state_t;

    state_t state;
    state_t state_nxt;
    logic   accept;

    // Current instruction actually leaves ID this cycle
    assign accept = (state == s_idle) && !data_hazard && !ex_stall;

    always_comb begin
        state_nxt = state;
        case (state)
            s_idle: begin
                if (accept && hlt) begin
                    state_nxt = s_halted;
                end else if (accept && xfer) begin
                    state_nxt = s_drain;
                end
            end
            s_drain:   if (timer_done) state_nxt = s_wait_pc;
            s_wait_pc: if (pc_update)  state_nxt = s_idle;      // Pulse ignored elsewhere
            s_halted:  state_nxt = s_halted;                    // Only rst leaves
            default:   state_nxt = s_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= s_idle;
        end else begin
            state <= state_nxt;
        end
    end

    assign timer_start = accept && xfer && !hlt;    // Same edge as entry to DRAIN
    assign ctrl_hazard = (state == s_drain) || (state == s_wait_pc);
    assign halted      = (state == s_halted);

endmodule

`default_nettype wire

// ==== src/ctrl_decode.sv ====
// Pure table decode of the opcode; unused read ports default to rs/rt and take no part in hazards
`default_nettype none
`timescale 1ns/1ps

module ctrl_decode (
    input  logic [3:0]         opcode,
    output id_pkg::ctrl_word_t ctrl,
    output logic [1:0]         sel_1,       // 0 rs, 1 dest field, 2 r14, 3 r15
    output logic               sel_2,       // 0 rt, 1 dest field
    output logic               use_1,
    output logic               use_2,
    output logic               imm8_sel,    // Sign-extend imm8 instead of imm4
    output logic               xfer,        // branch, call or ret
    output logic               hlt
);

    import id_pkg::*;

    always_comb begin
        // Bubble unless the opcode says otherwise
        ctrl     = ctrl_bubble;
        sel_1    = 2'd0;
        sel_2    = 1'b0;
        use_1    = 1'b0;
        use_2    = 1'b0;
        imm8_sel = 1'b0;
        xfer     = 1'b0;
        hlt      = 1'b0;

        case (opcode)
            op_add, op_sub, op_nand, op_xor, op_inc: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = opcode[2:0];
                use_1          = 1'b1;          // rs
                use_2          = 1'b1;          // rt
            end
            op_sra, op_srl, op_sll: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = opcode[2:0];
                ctrl.alu_src   = 1'b1;          // Shift amount from imm4
                use_1          = 1'b1;
            end
            op_lw: begin
                ctrl.reg_write  = 1'b1;
                ctrl.mem_read   = 1'b1;
                ctrl.mem_to_reg = 1'b1;
                ctrl.alu_src    = 1'b1;
                ctrl.alu_op     = 3'd0;         // r14 + imm8
                sel_1           = 2'd2;
                use_1           = 1'b1;
                imm8_sel        = 1'b1;
            end
            op_sw: begin
                ctrl.mem_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                ctrl.alu_op    = 3'd0;
                sel_1          = 2'd2;          // Address base r14
                sel_2          = 1'b1;          // Store data from dest field
                use_1          = 1'b1;
                use_2          = 1'b1;
                imm8_sel       = 1'b1;
            end
            op_lhb, op_llb: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                ctrl.alu_op    = 3'd0;
                ctrl.load_half = 1'b1;
                ctrl.half_spec = opcode[0];     // llb is the odd one
                sel_1          = 2'd1;          // Keeps the other half of rd
                use_1          = 1'b1;
                imm8_sel       = 1'b1;
            end
            op_b: begin
                ctrl.branch = 1'b1;             // Condition resolved in EX
                xfer        = 1'b1;
            end
            op_call: begin
                ctrl.call = 1'b1;
                sel_1     = 2'd3;               // SP
                use_1     = 1'b1;
                xfer      = 1'b1;
            end
            op_ret: begin
                ctrl.ret = 1'b1;
                sel_1    = 2'd3;
                use_1    = 1'b1;
                xfer     = 1'b1;
            end
            op_hlt: hlt = 1'b1;                 // Control stays a bubble
        endcase
    end

endmodule

`default_nettype wire

// ==== src/reg_file.sv ====
// 16x16 register file; reads are combinational, a write is only visible in the next cycle
`default_nettype none
`timescale 1ns/1ps

module reg_file (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      wr_en,
    input  logic [id_pkg::reg_w-1:0]  rd_addr_1,
    input  logic [id_pkg::reg_w-1:0]  rd_addr_2,
    input  logic [id_pkg::reg_w-1:0]  wr_addr,
    input  logic [id_pkg::data_w-1:0] wr_data,
    output logic [id_pkg::data_w-1:0] rd_data_1,
    output logic [id_pkg::data_w-1:0] rd_data_2
);

    import id_pkg::*;

    localparam int n_regs = 2 ** reg_w;

    logic [data_w-1:0] regs [n_regs];

    // Reset gives SP its top-of-memory value, everything else zero
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < n_regs; i++) begin
                regs[i] <= (i == int'(reg_sp)) ? sp_reset : '0;
            end
        end else if (wr_en) begin
            regs[wr_addr] <= wr_data;       // Lands on this edge
        end
    end

    // No bypass from the write port
    assign rd_data_1 = regs[rd_addr_1];
    assign rd_data_2 = regs[rd_addr_2];

endmodule

`default_nettype wire

// ==== src/id_pkg.sv ====
// Shared decode definitions for the 16-bit ID stage; opcodes are fixed 4-bit, r14/r15 are special
`default_nettype none

package id_pkg;

    // Datapath widths
    localparam int data_w = 16;                 // Data and PC width
    localparam int reg_w  = 4;                  // Register index width

    // Opcodes, inst[15:12]
    localparam logic [3:0] op_add  = 4'h0;
    localparam logic [3:0] op_sub  = 4'h1;
    localparam logic [3:0] op_nand = 4'h2;
    localparam logic [3:0] op_xor  = 4'h3;
    localparam logic [3:0] op_inc  = 4'h4;
    localparam logic [3:0] op_sra  = 4'h5;
    localparam logic [3:0] op_srl  = 4'h6;
    localparam logic [3:0] op_sll  = 4'h7;
    localparam logic [3:0] op_lw   = 4'h8;
    localparam logic [3:0] op_sw   = 4'h9;
    localparam logic [3:0] op_lhb  = 4'hA;
    localparam logic [3:0] op_llb  = 4'hB;
    localparam logic [3:0] op_b    = 4'hC;
    localparam logic [3:0] op_call = 4'hD;
    localparam logic [3:0] op_ret  = 4'hE;
    localparam logic [3:0] op_hlt  = 4'hF;

    // Special registers
    localparam logic [reg_w-1:0]  reg_ds   = 4'd14;     // Data segment base for lw/sw
    localparam logic [reg_w-1:0]  reg_sp   = 4'd15;     // Stack pointer for call/ret
    localparam logic [data_w-1:0] sp_reset = 16'hFFFF;  // SP value out of reset

    localparam logic [2:0] alu_nop         = 3'b111;    // ALU does nothing
    localparam int         redirect_cycles = 3;         // Bubbles after branch/call/ret

    // Control word toward EX/MEM/WB
    typedef struct packed {
        logic       reg_write;
        logic       mem_write;
        logic       mem_read;
        logic       mem_to_reg;     // WB takes memory data
        logic       alu_src;        // ALU operand B is the immediate
        logic [2:0] alu_op;
        logic       branch;
        logic       call;
        logic       ret;
        logic       load_half;      // lhb or llb
        logic       half_spec;      // 0 lhb, 1 llb
    } ctrl_word_t;

    // Operands and instruction fields toward EX
    typedef struct packed {
        logic [data_w-1:0] read_data_1;
        logic [data_w-1:0] read_data_2;
        logic [data_w-1:0] sign_ext;
        logic [reg_w-1:0]  dest_reg;
        logic [2:0]        branch_cond;
        logic [11:0]       call_target;
        logic [data_w-1:0] pc;
    } data_word_t;

    // Bubble values
    localparam ctrl_word_t ctrl_bubble = '{alu_op: alu_nop, default: '0};
    localparam data_word_t data_bubble = '0;

endpackage

`default_nettype wire
